/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Byte offset inside an 8-byte line
    localparam int offset_bits = 3;

    localparam int default_line_count = 16;
    // One entry per nonzero memory tag
    localparam int default_mshr_depth = 15;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] mem_tag_t;
    typedef logic [31-offset_bits:0] line_tag_t;

    // Same 64 bits seen at three granularities
    typedef union packed {
        logic [63:0] dword;
        word_t [1:0] words;
        logic [7:0][7:0] bytes;
    } mem_block_t;

    // Line tag of a byte address
    function automatic line_tag_t line_of(input addr_t addr);
        return addr[31:offset_bits];
    endfunction

    // Word select inside the line, 1 picks the upper word
    function automatic logic word_of(input addr_t addr);
        return addr[2];
    endfunction

endpackage

`default_nettype wire

/* source/dcache_miss_request.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_miss_request (
    input  wire logic                     store_valid,
    input  wire dcache_pkg::addr_t        store_addr,
    input  wire logic                     store_hit,
    input  wire logic [1:0]               load_valid,
    input  wire dcache_pkg::addr_t [1:0]  load_addr,
    input  wire logic [1:0]               load_hit,
    input  wire logic                     refill_valid,
    input  wire logic                     mem_write_valid,
    input  wire logic                     miss_pending,
    output logic                          store_write,
    output dcache_pkg::line_tag_t         miss_tag,
    output logic                          mem_req_valid,
    output dcache_pkg::line_tag_t         mem_req_tag
);

    logic       store_miss;
    logic [1:0] load_miss;
    logic       miss_valid;

    // Store completes only on a hit and when the line store is free
    assign store_write = store_valid && store_hit && !refill_valid;

    assign store_miss = store_valid && !store_hit;
    assign load_miss = load_valid & ~load_hit;

    // Store first, then the older load port, then the younger one
    always_comb begin
        miss_valid = 1'b0;
        miss_tag = '0;
        if (store_miss) begin
            miss_valid = 1'b1;
            miss_tag = dcache_pkg::line_of(store_addr);
        end else if (load_miss[0]) begin
            miss_valid = 1'b1;
            miss_tag = dcache_pkg::line_of(load_addr[0]);
        end else if (load_miss[1]) begin
            miss_valid = 1'b1;
            miss_tag = dcache_pkg::line_of(load_addr[1]);
        end
    end

    // Writeback owns the memory port this cycle
    // and a line already in flight is not asked for twice
    assign mem_req_valid = miss_valid && !mem_write_valid && !miss_pending;
    assign mem_req_tag = miss_tag;

endmodule

`default_nettype wire

/* source/dcache_mshr.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_mshr #(
    parameter int mshr_depth = 15
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire dcache_pkg::line_tag_t    miss_tag,
    output logic                          miss_pending,
    input  wire dcache_pkg::line_tag_t    mem_req_tag,
    input  wire logic                     mem_req_accepted,
    input  wire dcache_pkg::mem_tag_t     current_req_tag,
    input  wire dcache_pkg::mem_tag_t     mem_data_tag,
    output logic                          refill_valid,
    output dcache_pkg::line_tag_t         refill_tag
);

    localparam int ptr_bits = $clog2(mshr_depth);

    logic [mshr_depth-1:0]       entry_valid;
    dcache_pkg::mem_tag_t        entry_mem_tag [mshr_depth];
    dcache_pkg::line_tag_t       entry_line_tag [mshr_depth];

    logic [ptr_bits-1:0]         head;
    logic [ptr_bits-1:0]         tail;
    logic [ptr_bits-1:0]         head_next;
    logic [ptr_bits-1:0]         tail_next;
    logic                        push;
    logic                        pop;

    // Duplicate check across every outstanding entry
    always_comb begin
        miss_pending = 1'b0;
        for (int i = 0; i < mshr_depth; i++) begin
            if (entry_valid[i] && entry_line_tag[i] == miss_tag) begin
                miss_pending = 1'b1;
            end
        end
    end

    // Only the head may retire, memory returns in order
    assign pop = (mem_data_tag != '0) && entry_valid[head] &&
                 (entry_mem_tag[head] == mem_data_tag);
    assign push = mem_req_accepted && (current_req_tag != '0);

    assign refill_valid = pop;
    assign refill_tag = entry_line_tag[head];

    assign head_next = (head == ptr_bits'(mshr_depth - 1)) ? '0 : head + 1'b1;
    assign tail_next = (tail == ptr_bits'(mshr_depth - 1)) ? '0 : tail + 1'b1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            entry_valid <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (pop) begin
                entry_valid[head] <= 1'b0;
                head <= head_next;
            end
            if (push) begin
                entry_valid[tail] <= 1'b1;
                tail <= tail_next;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entry_mem_tag[tail] <= current_req_tag;
            entry_line_tag[tail] <= mem_req_tag;
        end
    end

endmodule

`default_nettype wire

/* source/dcache_lines.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_lines #(
    parameter int line_count = 16
) (
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire logic [1:0]                       load_valid,
    input  wire dcache_pkg::addr_t [1:0]          load_addr,
    output logic [1:0]                            load_hit,
    output dcache_pkg::mem_block_t [1:0]          load_data,
    input  wire dcache_pkg::addr_t                store_addr,
    input  wire dcache_pkg::word_t                store_data,
    input  wire logic                             store_write,
    output logic                                  store_hit,
    input  wire logic                             refill_valid,
    input  wire dcache_pkg::line_tag_t            refill_tag,
    input  wire dcache_pkg::mem_block_t           mem_data,
    output logic                                  mem_write_valid,
    output dcache_pkg::line_tag_t                 mem_write_tag,
    output dcache_pkg::mem_block_t                mem_write_data
);

    localparam int index_bits = $clog2(line_count);
    // One extra bit so every line index comes up after the modulo
    localparam int lfsr_width = index_bits + 1;

    // Maximal-length feedback taps for small widths
    function automatic logic [8:0] lfsr_taps(input int width);
        case (width)
            2: return 9'b0_0000_0011;
            3: return 9'b0_0000_0110;
            4: return 9'b0_0000_1100;
            5: return 9'b0_0001_0100;
            6: return 9'b0_0011_0000;
            7: return 9'b0_0110_0000;
            8: return 9'b0_1011_1000;
            default: return 9'b1_0001_0000;
        endcase
    endfunction

    localparam logic [lfsr_width-1:0] lfsr_mask = lfsr_width'(lfsr_taps(lfsr_width));

    logic [line_count-1:0]       line_valid;
    logic [line_count-1:0]       line_dirty;
    dcache_pkg::line_tag_t       line_tag [line_count];
    dcache_pkg::mem_block_t      line_data [line_count];

    logic [lfsr_width-1:0]       lfsr;
    logic [index_bits-1:0]       victim_index;
    logic [index_bits-1:0]       free_index;
    logic                        free_found;
    logic [index_bits-1:0]       fill_index;
    logic [index_bits-1:0]       store_index;
    dcache_pkg::mem_block_t      merged_data;
    logic                        store_changed;

    // Load lookups on both ports
    always_comb begin
        load_hit = '0;
        load_data = '0;
        for (int j = 0; j < 2; j++) begin
            for (int i = 0; i < line_count; i++) begin
                if (load_valid[j] && line_valid[i] &&
                    line_tag[i] == dcache_pkg::line_of(load_addr[j])) begin
                    load_hit[j] = 1'b1;
                    load_data[j] = line_data[i];
                end
            end
        end
    end

    // Store lookup and word merge
    always_comb begin
        store_hit = 1'b0;
        store_index = '0;
        for (int i = 0; i < line_count; i++) begin
            if (line_valid[i] && line_tag[i] == dcache_pkg::line_of(store_addr)) begin
                store_hit = 1'b1;
                store_index = index_bits'(i);
            end
        end
        merged_data = line_data[store_index];
        merged_data.words[dcache_pkg::word_of(store_addr)] = store_data;
        store_changed = (merged_data != line_data[store_index]);
    end

    // Lowest free line wins, scan runs downward
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = line_count - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_found = 1'b1;
                free_index = index_bits'(i);
            end
        end
    end

    assign victim_index = index_bits'(lfsr % line_count);
    assign fill_index = free_found ? free_index : victim_index;

    // Dirty victim leaves in the refill cycle
    assign mem_write_valid = refill_valid && !free_found &&
                             line_valid[victim_index] && line_dirty[victim_index];
    assign mem_write_tag = line_tag[victim_index];
    assign mem_write_data = line_data[victim_index];

    always_ff @(posedge clock) begin
        if (!reset) begin
            line_valid <= '0;
            line_dirty <= '0;
            lfsr <= lfsr_width'(1);
        end else begin
            lfsr <= {lfsr[lfsr_width-2:0], ^(lfsr & lfsr_mask)};
            if (refill_valid) begin
                line_valid[fill_index] <= 1'b1;
                line_dirty[fill_index] <= 1'b0;
            end else if (store_write) begin
                line_dirty[store_index] <= line_dirty[store_index] | store_changed;
            end
        end
    end

    // Line payload, refill has priority over the store
    always_ff @(posedge clock) begin
        if (refill_valid) begin
            line_tag[fill_index] <= refill_tag;
            line_data[fill_index] <= mem_data;
        end else if (store_write) begin
            line_data[store_index] <= merged_data;
        end
    end

endmodule

`default_nettype wire

/* source/dcache_subsystem.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_subsystem #(
    parameter int line_count = dcache_pkg::default_line_count,
    parameter int mshr_depth = dcache_pkg::default_mshr_depth
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    // Load ports, port 0 is the older one
    input  wire logic [1:0]               load_valid,
    input  wire dcache_pkg::addr_t [1:0]  load_addr,
    output logic [1:0]                    load_hit,
    output dcache_pkg::mem_block_t [1:0]  load_data,
    // Word stores
    input  wire logic                     store_valid,
    input  wire dcache_pkg::addr_t        store_addr,
    input  wire dcache_pkg::word_t        store_data,
    output logic                          store_response,
    // Memory read requests
    output logic                          mem_req_valid,
    output dcache_pkg::line_tag_t         mem_req_tag,
    input  wire logic                     mem_req_accepted,
    input  wire dcache_pkg::mem_tag_t     current_req_tag,
    // Memory data return
    input  wire dcache_pkg::mem_tag_t     mem_data_tag,
    input  wire dcache_pkg::mem_block_t   mem_data,
    // Dirty writebacks
    output logic                          mem_write_valid,
    output dcache_pkg::line_tag_t         mem_write_tag,
    output dcache_pkg::mem_block_t        mem_write_data
);

    logic                        store_hit;
    logic                        miss_pending;
    logic                        refill_valid;
    dcache_pkg::line_tag_t       miss_tag;
    dcache_pkg::line_tag_t       refill_tag;

    dcache_miss_request miss_request (
        .store_valid     (store_valid),
        .store_addr      (store_addr),
        .store_hit       (store_hit),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_hit        (load_hit),
        .refill_valid    (refill_valid),
        .mem_write_valid (mem_write_valid),
        .miss_pending    (miss_pending),
        .store_write     (store_response),
        .miss_tag        (miss_tag),
        .mem_req_valid   (mem_req_valid),
        .mem_req_tag     (mem_req_tag)
    );

    dcache_mshr #(
        .mshr_depth (mshr_depth)
    ) mshr (
        .clock            (clock),
        .reset            (reset),
        .miss_tag         (miss_tag),
        .miss_pending     (miss_pending),
        .mem_req_tag      (mem_req_tag),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .mem_data_tag     (mem_data_tag),
        .refill_valid     (refill_valid),
        .refill_tag       (refill_tag)
    );

    // The store response doubles as the line write enable
    dcache_lines #(
        .line_count (line_count)
    ) lines (
        .clock           (clock),
        .reset           (reset),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_hit        (load_hit),
        .load_data       (load_data),
        .store_addr      (store_addr),
        .store_data      (store_data),
        .store_write     (store_response),
        .store_hit       (store_hit),
        .refill_valid    (refill_valid),
        .refill_tag      (refill_tag),
        .mem_data        (mem_data),
        .mem_write_valid (mem_write_valid),
        .mem_write_tag   (mem_write_tag),
        .mem_write_data  (mem_write_data)
    );

endmodule

`default_nettype wire

/* testbench/dcache_tb_memory.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_tb_memory #(
    parameter int latency = 4
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     mem_req_valid,
    input  wire dcache_pkg::line_tag_t    mem_req_tag,
    output logic                          mem_req_accepted,
    output dcache_pkg::mem_tag_t          current_req_tag,
    output dcache_pkg::mem_tag_t          mem_data_tag,
    output dcache_pkg::mem_block_t        mem_data,
    input  wire logic                     mem_write_valid,
    input  wire dcache_pkg::line_tag_t    mem_write_tag,
    input  wire dcache_pkg::mem_block_t   mem_write_data
);

    // Written back lines where the latest entry for a tag wins
    dcache_pkg::line_tag_t     written_tag [$];
    logic [63:0]               written_data [$];
    // Requests in flight with the oldest first
    dcache_pkg::line_tag_t     pending_line [$];
    dcache_pkg::mem_tag_t      pending_tag [$];
    int                        pending_due [$];
    dcache_pkg::mem_tag_t      next_tag;
    int                        cycle;

    // Lower word mixes the byte address with a constant
    // and the upper word is the inverted address of that word
    function automatic logic [63:0] initial_block(input dcache_pkg::line_tag_t tag);
        return {~{tag, 3'b100}, {tag, 3'b000} ^ 32'h5a3c_96e1};
    endfunction

    function automatic logic [63:0] read_block(input dcache_pkg::line_tag_t tag);
        logic [63:0] block;
        block = initial_block(tag);
        for (int i = 0; i < written_tag.size(); i++) begin
            if (written_tag[i] == tag) begin
                block = written_data[i];
            end
        end
        return block;
    endfunction

    initial begin
        next_tag = 4'd1;
        cycle = 0;
        mem_data_tag = '0;
        mem_data = '0;
    end

    // Every request is taken in the cycle it appears
    assign mem_req_accepted = mem_req_valid;
    assign current_req_tag = next_tag;

    always @(posedge clock) begin
        if (!reset) begin
            next_tag <= 4'd1;
            cycle = 0;
            pending_line.delete();
            pending_tag.delete();
            pending_due.delete();
        end else begin
            cycle = cycle + 1;
            if (mem_req_accepted) begin
                pending_line.push_back(mem_req_tag);
                pending_tag.push_back(next_tag);
                pending_due.push_back(cycle + latency);
                // Tags 1 to 15 in rotation and never zero
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            if (mem_write_valid) begin
                written_tag.push_back(mem_write_tag);
                written_data.push_back(mem_write_data);
            end
        end
    end

    // Return data is driven for one cycle in request order
    always @(negedge clock) begin
        mem_data_tag = '0;
        mem_data = '0;
        if (pending_due.size() > 0 && pending_due[0] <= cycle) begin
            mem_data_tag = pending_tag.pop_front();
            mem_data = read_block(pending_line.pop_front());
            void'(pending_due.pop_front());
        end
    end

endmodule

`default_nettype wire

/* testbench/dcache_subsystem_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_subsystem_tb;

    localparam int line_count = dcache_pkg::default_line_count;
    localparam int mshr_depth = dcache_pkg::default_mshr_depth;
    localparam int wait_limit = 200;

    logic                          clock;
    logic                          reset;
    logic [1:0]                    load_valid;
    dcache_pkg::addr_t [1:0]       load_addr;
    logic [1:0]                    load_hit;
    dcache_pkg::mem_block_t [1:0]  load_data;
    logic                          store_valid;
    dcache_pkg::addr_t             store_addr;
    dcache_pkg::word_t             store_data;
    logic                          store_response;
    logic                          mem_req_valid;
    dcache_pkg::line_tag_t         mem_req_tag;
    logic                          mem_req_accepted;
    dcache_pkg::mem_tag_t          current_req_tag;
    dcache_pkg::mem_tag_t          mem_data_tag;
    dcache_pkg::mem_block_t        mem_data;
    logic                          mem_write_valid;
    dcache_pkg::line_tag_t         mem_write_tag;
    dcache_pkg::mem_block_t        mem_write_data;

    // Words that got a store response keyed by line tag and word select
    logic [29:0]                   stored_key [$];
    logic [31:0]                   stored_value [$];
    int                            error_count;
    int                            check_count;
    int                            writeback_count;
    integer                        seed;

    dcache_subsystem #(
        .line_count (line_count),
        .mshr_depth (mshr_depth)
    ) UUT (.*);

    dcache_tb_memory memory (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Position of the latest store to a word or -1 when there is none
    function automatic int find_word(input logic [29:0] key);
        int found;
        found = -1;
        for (int i = 0; i < stored_key.size(); i++) begin
            if (stored_key[i] == key) begin
                found = i;
            end
        end
        return found;
    endfunction

    // Initial line content with every answered store laid over it
    function automatic logic [63:0] expected_block(input dcache_pkg::line_tag_t tag);
        logic [63:0] block;
        int idx;
        block = memory.initial_block(tag);
        idx = find_word({tag, 1'b0});
        if (idx >= 0) begin
            block[31:0] = stored_value[idx];
        end
        idx = find_word({tag, 1'b1});
        if (idx >= 0) begin
            block[63:32] = stored_value[idx];
        end
        return block;
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < 2; p++) begin
                if (load_valid[p] && load_hit[p]) begin
                    check_count++;
                    if (load_data[p] !== expected_block(dcache_pkg::line_of(load_addr[p]))) begin
                        error_count++;
                        $display("** Error at %0t: port %0d load of %h gave %h, expected %h",
                                 $time, p, load_addr[p], load_data[p],
                                 expected_block(dcache_pkg::line_of(load_addr[p])));
                    end
                end
            end
            if (mem_write_valid) begin
                writeback_count++;
                check_count++;
                if (find_word({mem_write_tag, 1'b0}) < 0 &&
                    find_word({mem_write_tag, 1'b1}) < 0) begin
                    error_count++;
                    $display("** Error at %0t: writeback of line %h that had no store",
                             $time, mem_write_tag);
                end
                if (mem_write_data !== expected_block(mem_write_tag)) begin
                    error_count++;
                    $display("** Error at %0t: writeback of line %h gave %h, expected %h",
                             $time, mem_write_tag, mem_write_data, expected_block(mem_write_tag));
                end
            end
            // The store lands on this edge after the lookups above
            if (store_valid && store_response) begin
                stored_key.push_back({dcache_pkg::line_of(store_addr),
                                      dcache_pkg::word_of(store_addr)});
                stored_value.push_back(store_data);
            end
        end
    end

    task automatic set_loads(input logic [1:0] valid, input dcache_pkg::addr_t addr_0,
                             input dcache_pkg::addr_t addr_1);
        @(negedge clock);
        load_valid = valid;
        load_addr[0] = addr_0;
        load_addr[1] = addr_1;
    endtask

    // Counts requests for watch_line until every port in ports hits
    task automatic wait_hit(input logic [1:0] ports, input dcache_pkg::line_tag_t watch_line,
                            output int requests, output dcache_pkg::line_tag_t first_tag);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        requests = 0;
        first_tag = '0;
        do begin
            @(posedge clock);
            cycles++;
            if (mem_req_valid) begin
                if (!seen) begin
                    first_tag = mem_req_tag;
                end
                seen = 1'b1;
                if (mem_req_tag == watch_line) begin
                    requests++;
                end
            end
        end while ((load_hit & ports) != ports && cycles < wait_limit);
        if ((load_hit & ports) != ports) begin
            error_count++;
            $display("Timeout at %0t: load ports %b never hit", $time, ports);
        end
    endtask

    // Holds one store until it is answered and counts refill data seen before that
    task automatic store_word(input dcache_pkg::addr_t addr, input dcache_pkg::word_t data,
                              output int returns_before);
        int cycles;
        cycles = 0;
        returns_before = 0;
        @(negedge clock);
        store_valid = 1'b1;
        store_addr = addr;
        store_data = data;
        do begin
            @(posedge clock);
            cycles++;
            if (!store_response && mem_data_tag != '0) begin
                returns_before++;
            end
        end while (!store_response && cycles < wait_limit);
        if (!store_response) begin
            error_count++;
            $display("Timeout at %0t: store to %h never got a response", $time, addr);
        end
        @(negedge clock);
        store_valid = 1'b0;
    endtask

    task automatic report_test(input int number, input int errors_before);
        $display("Test %0d finished with %0d errors", number, error_count - errors_before);
    endtask

    initial begin
        int requests;
        int returns;
        int mark;
        dcache_pkg::line_tag_t first_tag;
        dcache_pkg::addr_t addr;
        dcache_pkg::addr_t other_addr;
        dcache_pkg::addr_t stored_addr [$];
        seed = 32'h0979_c537;
        error_count = 0;
        check_count = 0;
        writeback_count = 0;
        reset = 1'b0;
        load_valid = '0;
        load_addr = '0;
        store_valid = 1'b0;
        store_addr = '0;
        store_data = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        // Single load miss on an empty cache
        mark = error_count;
        addr = 32'h0000_1040;
        set_loads(2'b01, addr, '0);
        wait_hit(2'b01, dcache_pkg::line_of(addr), requests, first_tag);
        if (requests != 1) begin
            error_count++;
            $display("** Error at %0t: %0d requests for line %h, expected 1",
                     $time, requests, dcache_pkg::line_of(addr));
        end
        set_loads(2'b00, '0, '0);
        report_test(1, mark);

        // Two misses where port 0 goes first
        mark = error_count;
        addr = 32'h0000_2000;
        other_addr = 32'h0000_3008;
        set_loads(2'b11, addr, other_addr);
        wait_hit(2'b11, dcache_pkg::line_of(addr), requests, first_tag);
        if (first_tag != dcache_pkg::line_of(addr)) begin
            error_count++;
            $display("** Error at %0t: first request named line %h, expected %h",
                     $time, first_tag, dcache_pkg::line_of(addr));
        end
        set_loads(2'b00, '0, '0);
        report_test(2, mark);

        // Store miss waits for its refill and the load then sees the merged word
        mark = error_count;
        addr = 32'h0000_4004;
        store_word(addr, 32'hc0de_1234, returns);
        if (returns == 0) begin
            error_count++;
            $display("** Error at %0t: store to %h answered before its refill", $time, addr);
        end
        set_loads(2'b01, addr, '0);
        wait_hit(2'b01, dcache_pkg::line_of(addr), requests, first_tag);
        set_loads(2'b00, '0, '0);
        report_test(3, mark);

        // Both ports keep asking for one outstanding line
        mark = error_count;
        addr = 32'h0000_5000;
        set_loads(2'b11, addr, addr | 32'h4);
        wait_hit(2'b11, dcache_pkg::line_of(addr), requests, first_tag);
        if (requests != 1) begin
            error_count++;
            $display("** Error at %0t: %0d requests for line %h, expected 1",
                     $time, requests, dcache_pkg::line_of(addr));
        end
        set_loads(2'b00, '0, '0);
        report_test(4, mark);

        // Overfill with random lines and store to every other one before reloading those
        mark = error_count;
        for (int n = 0; n < 3 * line_count; n++) begin
            addr = $random(seed) & 32'h000f_fffc;
            set_loads(2'b01, addr, '0);
            wait_hit(2'b01, dcache_pkg::line_of(addr), requests, first_tag);
            set_loads(2'b00, '0, '0);
            if (n % 2 == 0) begin
                store_word(addr, $random(seed), returns);
                stored_addr.push_back(addr);
            end
        end
        for (int i = 0; i < stored_addr.size(); i++) begin
            set_loads(2'b01, stored_addr[i], '0);
            wait_hit(2'b01, dcache_pkg::line_of(stored_addr[i]), requests, first_tag);
            set_loads(2'b00, '0, '0);
        end
        if (writeback_count == 0) begin
            error_count++;
            $display("No dirty line was written back while overfilling the cache");
        end
        report_test(5, mark);

        $display("Checks: %0d, writebacks: %0d, errors: %0d",
                 check_count, writeback_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
source/dcache_pkg.sv
source/dcache_miss_request.sv
source/dcache_mshr.sv
source/dcache_lines.sv
source/dcache_subsystem.sv
testbench/dcache_tb_memory.sv
testbench/dcache_subsystem_tb.sv
